// File: design/axi_bus_pkg.sv
// ****************************************
// AXI4 write-channel types
// Bus widths, packed payload structs for the
// AW, W and B channels, and response codes.
// Import into any module that carries AXI
// write traffic.
// ****************************************

package axi_bus_pkg;

    localparam int AXI_ID_W   = 8;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Write address, user field not carried
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [3:0]            qos;
        logic [3:0]            region;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

endpackage

// File: design/wr_fifo_pkg.sv
// ****************************************
// Types for the write FIFO subsystem
// Address-gate FSM states and the burst beat
// counter used by the address gate.
// ****************************************

package wr_fifo_pkg;

    // Gate FSM
    //   GATE_IDLE   waiting for an address, W input held off
    //   GATE_FILL   address held, counting buffered beats
    //   GATE_DRAIN  address released early, counting to burst end
    typedef enum logic [1:0] {
        GATE_IDLE  = 2'd0,
        GATE_FILL  = 2'd1,
        GATE_DRAIN = 2'd2
    } aw_state_e;

    // Up to 256 beats per burst plus one bit of headroom
    typedef logic [8:0] beat_cnt_t;

endpackage

// File: design/aw_gate.sv
// ****************************************
// Write-address stage of the write FIFO
// FIFO_DELAY=0 passes AW straight through.
// FIFO_DELAY=1 holds the address until its
// burst is buffered or the FIFO is full, and
// drives hold to gate the W input.
// ****************************************

module aw_gate
    import axi_bus_pkg::*;
    import wr_fifo_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_DELAY = 1
) (
    input  logic    clk,
    input  logic    rst,

    input  axi_aw_t s_aw,
    input  logic    s_awvalid,
    output logic    s_awready,

    // Accepted W beat on the slave side
    input  logic    w_beat,

    output axi_aw_t m_aw,
    output logic    m_awvalid,
    input  logic    m_awready,

    output logic    hold
);

    generate
        if (FIFO_DELAY != 0) begin : g_delay
            aw_state_e state_reg, state_next;
            beat_cnt_t cnt_reg, cnt_next;
            axi_aw_t   aw_reg, aw_next;
            logic      hold_reg, hold_next;
            logic      awvalid_reg, awvalid_next;
            logic      awready_reg, awready_next;

            assign m_aw      = aw_reg;
            assign m_awvalid = awvalid_reg;
            assign s_awready = awready_reg;
            assign hold      = hold_reg;

            always_comb begin
                state_next   = state_reg;
                cnt_next     = cnt_reg;
                aw_next      = aw_reg;
                hold_next    = hold_reg;
                awvalid_next = awvalid_reg && !m_awready;
                awready_next = awready_reg;

                case (state_reg)
                    GATE_IDLE: begin
                        // Previous address must be gone before taking a new one
                        awready_next = !awvalid_reg || m_awready;
                        hold_next    = 1'b1;
                        if (s_awready && s_awvalid) begin
                            awready_next = 1'b0;
                            aw_next      = s_aw;
                            hold_next    = 1'b0;
                            cnt_next     = '0;
                            state_next   = GATE_FILL;
                        end
                    end
                    GATE_FILL: begin
                        awready_next = 1'b0;
                        hold_next    = 1'b0;
                        if (w_beat) begin
                            cnt_next = cnt_reg + 1'b1;
                            // Burst end wins when it coincides with FIFO full
                            if (cnt_reg == beat_cnt_t'(aw_reg.len)) begin
                                awvalid_next = 1'b1;
                                hold_next    = 1'b1;
                                state_next   = GATE_IDLE;
                            end else if (cnt_next == beat_cnt_t'(FIFO_DEPTH)) begin
                                awvalid_next = 1'b1;
                                state_next   = GATE_DRAIN;
                            end
                        end
                    end
                    GATE_DRAIN: begin
                        awready_next = 1'b0;
                        hold_next    = 1'b0;
                        if (w_beat) begin
                            cnt_next = cnt_reg + 1'b1;
                            if (cnt_reg == beat_cnt_t'(aw_reg.len)) begin
                                hold_next  = 1'b1;
                                state_next = GATE_IDLE;
                            end
                        end
                    end
                    default: begin
                        state_next = GATE_IDLE;
                    end
                endcase
            end

            always_ff @(posedge clk) begin
                state_reg   <= state_next;
                cnt_reg     <= cnt_next;
                aw_reg      <= aw_next;
                hold_reg    <= hold_next;
                awvalid_reg <= awvalid_next;
                awready_reg <= awready_next;
                if (rst) begin
                    state_reg   <= GATE_IDLE;
                    hold_reg    <= 1'b1;
                    awvalid_reg <= 1'b0;
                    awready_reg <= 1'b0;
                end
            end

            // Held address must not change before the slave takes it
            assert property (@(posedge clk) disable iff (rst)
                m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw));

            // W input stays closed while no address is pending
            assert property (@(posedge clk) disable iff (rst)
                state_reg == GATE_IDLE |-> hold);
        end else begin : g_bypass
            assign m_aw      = s_aw;
            assign m_awvalid = s_awvalid;
            assign s_awready = m_awready;
            assign hold      = 1'b0;
        end
    endgenerate

endmodule

// File: design/w_fifo.sv
// ****************************************
// Write-data FIFO
// Stores W beats in order. A registered
// memory read feeds an output register that
// holds under back-pressure. FIFO_DEPTH must
// be a power of two.
// ****************************************

module w_fifo
    import axi_bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic   clk,
    input  logic   rst,

    input  axi_w_t s_w,
    input  logic   s_wvalid,
    input  logic   hold,
    output logic   w_accept,

    output axi_w_t m_w,
    output logic   m_wvalid,
    input  logic   m_wready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // Pointers carry one extra wrap bit
    logic [ADDR_W:0] wr_ptr_reg, wr_ptr_next;
    logic [ADDR_W:0] rd_ptr_reg, rd_ptr_next;
    logic [ADDR_W:0] wr_addr_reg;
    logic [ADDR_W:0] rd_addr_reg;
    logic [ADDR_W:0] fill_level;

    axi_w_t mem [FIFO_DEPTH];
    axi_w_t mem_rd_data_reg;
    logic   mem_rd_valid_reg, mem_rd_valid_next;

    axi_w_t m_w_reg;
    logic   m_wvalid_reg;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic store_output;

    assign full  = (wr_ptr_reg[ADDR_W] != rd_ptr_reg[ADDR_W]) &&
                   (wr_ptr_reg[ADDR_W-1:0] == rd_ptr_reg[ADDR_W-1:0]);
    assign empty = (wr_ptr_reg == rd_ptr_reg);

    assign fill_level = wr_ptr_reg - rd_ptr_reg;

    assign w_accept    = !full && !hold;
    assign write       = s_wvalid && w_accept;
    assign wr_ptr_next = write ? wr_ptr_reg + 1'b1 : wr_ptr_reg;

    always_ff @(posedge clk) begin
        wr_ptr_reg  <= wr_ptr_next;
        wr_addr_reg <= wr_ptr_next;
        if (write) begin
            mem[wr_addr_reg[ADDR_W-1:0]] <= s_w;
        end
        if (rst) begin
            wr_ptr_reg  <= '0;
            wr_addr_reg <= '0;
        end
    end

    // Pull from memory when the read stage is empty or moving on
    always_comb begin
        read              = 1'b0;
        rd_ptr_next       = rd_ptr_reg;
        mem_rd_valid_next = mem_rd_valid_reg;
        if (store_output || !mem_rd_valid_reg) begin
            read              = !empty;
            mem_rd_valid_next = !empty;
            if (!empty) begin
                rd_ptr_next = rd_ptr_reg + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_ptr_reg       <= rd_ptr_next;
        rd_addr_reg      <= rd_ptr_next;
        mem_rd_valid_reg <= mem_rd_valid_next;
        if (read) begin
            mem_rd_data_reg <= mem[rd_addr_reg[ADDR_W-1:0]];
        end
        if (rst) begin
            rd_ptr_reg       <= '0;
            rd_addr_reg      <= '0;
            mem_rd_valid_reg <= 1'b0;
        end
    end

    // Output register
    assign store_output = m_wready || !m_wvalid_reg;

    always_ff @(posedge clk) begin
        if (store_output) begin
            m_w_reg      <= mem_rd_data_reg;
            m_wvalid_reg <= mem_rd_valid_reg;
        end
        if (rst) begin
            m_wvalid_reg <= 1'b0;
        end
    end

    assign m_w      = m_w_reg;
    assign m_wvalid = m_wvalid_reg;

    // Stored beats never exceed the memory size
    assert property (@(posedge clk) disable iff (rst)
        fill_level <= (ADDR_W+1)'(FIFO_DEPTH));

    assert property (@(posedge clk) disable iff (rst)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_w));

endmodule

// File: design/axi_fifo_wr.sv
// ****************************************
// AXI4 write FIFO, top level
// W beats pass through a FIFO; AW passes
// through or waits for its burst when
// FIFO_DELAY is 1. B passes straight through.
// ****************************************

module axi_fifo_wr
    import axi_bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_DELAY = 1
) (
    input  logic    clk,
    input  logic    rst,

    // Slave side, facing the AXI master
    input  axi_aw_t s_aw,
    input  logic    s_awvalid,
    output logic    s_awready,
    input  axi_w_t  s_w,
    input  logic    s_wvalid,
    output logic    s_wready,
    output axi_b_t  s_b,
    output logic    s_bvalid,
    input  logic    s_bready,

    // Master side, facing the AXI slave
    output axi_aw_t m_aw,
    output logic    m_awvalid,
    input  logic    m_awready,
    output axi_w_t  m_w,
    output logic    m_wvalid,
    input  logic    m_wready,
    input  axi_b_t  m_b,
    input  logic    m_bvalid,
    output logic    m_bready
);

    logic hold;
    logic w_accept;
    logic w_beat;

    assign s_wready = w_accept;
    assign w_beat   = s_wvalid && w_accept;

    aw_gate #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY)
    ) u_aw_gate (
        .clk       (clk),
        .rst       (rst),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .w_beat    (w_beat),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .hold      (hold)
    );

    w_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_w_fifo (
        .clk      (clk),
        .rst      (rst),
        .s_w      (s_w),
        .s_wvalid (s_wvalid),
        .hold     (hold),
        .w_accept (w_accept),
        .m_w      (m_w),
        .m_wvalid (m_wvalid),
        .m_wready (m_wready)
    );

    // Response bypass
    assign s_b      = m_b;
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;

endmodule

// File: tests/tb_axi_fifo_wr.sv
// ****************************************
// Testbench for the AXI4 write FIFO
// Sends bursts from a table into the slave
// port. A sink on the master port takes them,
// with optional W stalls, and the bench checks
// address, beat order, release point and B.
// ****************************************

module tb_axi_fifo_wr
    import axi_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 500;

    typedef struct packed {
        logic [7:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [31:0] base;
        logic        stall;
        axi_resp_e   resp;
    } burst_t;

    logic    clk;
    logic    rst;
    axi_aw_t s_aw;
    logic    s_awvalid;
    logic    s_awready;
    axi_w_t  s_w;
    logic    s_wvalid;
    logic    s_wready;
    axi_b_t  s_b;
    logic    s_bvalid;
    logic    s_bready;
    axi_aw_t m_aw;
    logic    m_awvalid;
    logic    m_awready;
    axi_w_t  m_w;
    logic    m_wvalid;
    logic    m_wready;
    axi_b_t  m_b;
    logic    m_bvalid;
    logic    m_bready;

    burst_t  bursts[$];
    axi_w_t  got_w[$];
    axi_aw_t got_aw;
    logic    aw_seen;
    int      aw_at_beat;
    int      s_beats;
    int      test_errors;
    int      total_errors;
    int      failed_tests;
    logic    timed_out;
    integer  seed;

    axi_fifo_wr #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (1)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Both ports sampled mid-cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (!rst) begin
            if (m_awvalid && !aw_seen) begin
                aw_seen    = 1'b1;
                aw_at_beat = s_beats;
                got_aw     = m_aw;
            end
            if (s_wvalid && s_wready) begin
                s_beats++;
            end
            if (m_wvalid && m_wready) begin
                got_w.push_back(m_w);
            end
        end
    end

    function automatic axi_aw_t make_aw(input burst_t e);
        axi_aw_t aw;
        aw        = '0;
        aw.id     = e.id;
        aw.addr   = e.addr;
        aw.len    = e.len;
        aw.size   = 3'd2;
        aw.burst  = 2'b01;
        aw.cache  = 4'b0011;
        aw.prot   = 3'b010;
        aw.qos    = e.id[3:0];
        aw.region = e.id[7:4];
        return aw;
    endfunction

    // Master side sends the address, then len+1 beats
    task automatic send_burst(input burst_t e);
        int   b;
        int   n;
        logic ok;
        s_aw      = make_aw(e);
        s_awvalid = 1'b1;
        n         = 0;
        @(negedge clk);
        while (!s_awready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = s_awready;
        @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        if (!ok) begin
            $display("timeout: the DUT never took the write address");
            timed_out = 1'b1;
            return;
        end
        for (b = 0; b <= int'(e.len); b++) begin
            s_w.data = e.base + 32'(b);
            s_w.strb = '1;
            s_w.last = (b == int'(e.len));
            s_wvalid = 1'b1;
            n        = 0;
            @(negedge clk);
            while (!s_wready && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            ok = s_wready;
            @(posedge clk);
            #1;
            if (!ok) begin
                $display("timeout: the DUT stopped taking write beats at beat %0d", b);
                s_wvalid  = 1'b0;
                timed_out = 1'b1;
                return;
            end
        end
        s_wvalid = 1'b0;
    endtask

    // Slave side stalls W when asked and waits for the address and all beats
    task automatic sink_burst(input burst_t e);
        int n;
        n = 0;
        while ((got_w.size() < int'(e.len) + 1 || !aw_seen) && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            m_wready = e.stall ? (($random(seed) & 1) != 0) : 1'b1;
            n++;
        end
        m_wready = 1'b1;
        if (got_w.size() < int'(e.len) + 1 || !aw_seen) begin
            $display("timeout: only %0d beats and no complete burst reached the slave",
                     got_w.size());
            timed_out = 1'b1;
        end
        // A few idle cycles so a repeated beat would show up
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic check_burst(input burst_t e);
        int b;
        int want_at;
        want_at = (int'(e.len) + 1 < FIFO_DEPTH) ? int'(e.len) + 1 : FIFO_DEPTH;
        assert (got_aw == make_aw(e)) else begin
            $display("error at %0t: m_aw %h, expected %h", $time, got_aw, make_aw(e));
            test_errors++;
        end
        assert (aw_at_beat == want_at) else begin
            $display("error at %0t: address released after %0d beats, expected %0d",
                     $time, aw_at_beat, want_at);
            test_errors++;
        end
        assert (got_w.size() == int'(e.len) + 1) else begin
            $display("error at %0t: %0d beats on m_w, expected %0d",
                     $time, got_w.size(), int'(e.len) + 1);
            test_errors++;
        end
        for (b = 0; b < got_w.size() && b <= int'(e.len); b++) begin
            assert (got_w[b].data == e.base + 32'(b) && got_w[b].strb == '1 &&
                    got_w[b].last == (b == int'(e.len))) else begin
                $display("error at %0t: beat %0d data %h strb %h last %b, expected data %h",
                         $time, b, got_w[b].data, got_w[b].strb, got_w[b].last,
                         e.base + 32'(b));
                test_errors++;
            end
        end
    endtask

    // B passes without delay, so it is seen in the same cycle
    task automatic return_response(input burst_t e);
        axi_b_t want;
        want.id   = e.id;
        want.resp = e.resp;
        m_b       = want;
        m_bvalid  = 1'b1;
        s_bready  = 1'b1;
        @(negedge clk);
        assert (s_bvalid && m_bready && s_b == want) else begin
            $display("error at %0t: s_b id %h resp %0d valid %b, expected id %h resp %0d",
                     $time, s_b.id, s_b.resp, s_bvalid, want.id, want.resp);
            test_errors++;
        end
        @(posedge clk);
        #1;
        m_bvalid = 1'b0;
        s_bready = 1'b0;
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
    endtask

    initial begin
        int i;
        seed         = 32'hf8ed;
        rst          = 1'b1;
        s_aw         = '0;
        s_awvalid    = 1'b0;
        s_w          = '0;
        s_wvalid     = 1'b0;
        s_bready     = 1'b0;
        m_awready    = 1'b1;
        m_wready     = 1'b1;
        m_b          = '0;
        m_bvalid     = 1'b0;
        aw_seen      = 1'b0;
        aw_at_beat   = 0;
        s_beats      = 0;
        test_errors  = 0;
        total_errors = 0;
        failed_tests = 0;
        timed_out    = 1'b0;

        // id, addr, len, data base, stall W, response
        bursts.push_back('{8'h11, 32'h0000_1000, 8'd0, 32'hA000_0000, 1'b0, OKAY});
        bursts.push_back('{8'h22, 32'h0000_2040, 8'd3, 32'hB000_0100, 1'b0, SLVERR});
        bursts.push_back('{8'h33, 32'h0000_3000, 8'd7, 32'hC000_0200, 1'b0, OKAY});
        bursts.push_back('{8'h44, 32'h0001_0000, 8'd40, 32'hD000_0300, 1'b0, OKAY});
        bursts.push_back('{8'h55, 32'h0002_0080, 8'd7, 32'hE000_0400, 1'b1, SLVERR});
        bursts.push_back('{8'h66, 32'h0003_0000, 8'd40, 32'hF000_0500, 1'b1, OKAY});

        // First edge loads the reset values
        @(posedge clk);
        repeat (2) begin
            @(negedge clk);
            assert (!s_awready && !m_awvalid && !m_wvalid && !s_bvalid) else begin
                $display("error at %0t: outputs not idle during reset", $time);
                test_errors++;
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!m_awvalid && !m_wvalid && !s_bvalid) else begin
            $display("error at %0t: outputs not idle after reset", $time);
            test_errors++;
        end
        close_test("reset");

        for (i = 0; i < bursts.size(); i++) begin
            test_errors = 0;
            aw_seen     = 1'b0;
            s_beats     = 0;
            got_w.delete();
            @(posedge clk);
            #1;
            fork
                send_burst(bursts[i]);
                sink_burst(bursts[i]);
            join
            if (timed_out) begin
                $display("test burst %0d: stopped on a timeout", i);
                failed_tests++;
                break;
            end
            check_burst(bursts[i]);
            return_response(bursts[i]);
            close_test($sformatf("burst %0d len %0d stall %0b",
                                 i, bursts[i].len, bursts[i].stall));
        end

        $display("tests failed %0d, errors %0d, timeout %0b",
                 failed_tests, total_errors, timed_out);
        if (total_errors == 0 && failed_tests == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/axi_bus_pkg.sv
design/wr_fifo_pkg.sv
design/aw_gate.sv
design/w_fifo.sv
design/axi_fifo_wr.sv
tests/tb_axi_fifo_wr.sv

// File: run_sim.sh
#!/bin/sh
# Build the AXI write FIFO testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_axi_fifo_wr \
    -o sim_tb_axi_fifo_wr \
    && ./obj_dir/sim_tb_axi_fifo_wr > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0
